// File: files.f
hw/cr_pkg.sv
hw/cr_write_decode.sv
hw/cr_rw_regs.sv
hw/cr_thread_sampler.sv
hw/cr_read_port.sv
hw/cr_mem.sv
test/cr_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the control-register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cr_mem_tb -f files.f

out=$(./obj_dir/Vcr_mem_tb)
echo "$out"
echo "$out" | grep -qx "Regression passed"

// File: test/cr_mem_tb.sv
// Directed testbench of the control-register block
// Expected values come from a per-address model of the writable registers
// and from the pc values driven while each thread index was sampled
`timescale 1ns/1ps
`default_nettype none

module cr_mem_tb;

    localparam int MAX_CYCLES = 2000; // Tests take about 130 cycles

    logic                 qclk;
    logic                 reset;
    logic [7:0]           core_id_strap;
    cr_pkg::cr_req_t      core_req;
    cr_pkg::cr_req_t      ring_req;
    logic [3:0]           thread_onehot;
    logic [31:0]          pc;
    cr_pkg::thread_ctrl_t thread_ctrl;
    logic [31:0]          core_rd_data;
    logic [31:0]          ring_rd_data;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles = 0;
    logic        rotate;                 // Rotate thread input each cycle when set

    logic [31:0] exp_reg [logic [15:0]]; // Writable registers by address
    logic [15:0] writable [$];
    logic [15:0] rst_addr [4];
    logic [15:0] en_addr [4];
    logic [15:0] stk_addr [4];
    logic [15:0] tls_addr [4];
    logic [15:0] pc_addr [4];
    logic [15:0] pad_addr [4];
    logic [31:0] exp_pc [4];             // Last pc seen per sampled thread

    cr_mem i_dut (
        .qclk          (qclk),
        .reset         (reset),
        .core_id_strap (core_id_strap),
        .core_req      (core_req),
        .ring_req      (ring_req),
        .thread_onehot (thread_onehot),
        .pc            (pc),
        .thread_ctrl   (thread_ctrl),
        .core_rd_data  (core_rd_data),
        .ring_rd_data  (ring_rd_data)
    );

    initial qclk = 1'b0;
    always #2 qclk = ~qclk;

    always @(posedge qclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]}; // One step per bit
        end
    endtask

    // Thread after the execute thread with anything not one-hot counting as thread 3
    function automatic logic [1:0] next_idx(input logic [3:0] onehot);
        case (onehot)
            4'b0001 : return 2'd1;
            4'b0010 : return 2'd2;
            4'b0100 : return 2'd3;
            4'b1000 : return 2'd0;
            default : return 2'd3;
        endcase
    endfunction

    function automatic cr_pkg::cr_req_t make_req(input logic [15:0] addr,
                                                 input logic [31:0] data,
                                                 input logic rd, input logic wr);
        cr_pkg::cr_req_t r;
        r.addr    = addr;
        r.wr_data = data;
        r.rd_en   = rd;
        r.wr_en   = wr;
        return r;
    endfunction

    // Control bits keep only bit 0 of the written word
    function automatic logic [31:0] reg_value(input logic [15:0] addr, input logic [31:0] data);
        for (int t = 0; t < 4; t++) begin
            if (addr == rst_addr[t] || addr == en_addr[t]) begin
                return {31'd0, data[0]};
            end
        end
        return data;
    endfunction

    function automatic logic [7:0] exp_ctrl();
        logic [7:0] c;
        for (int t = 0; t < 4; t++) begin
            c[4+t] = exp_reg[rst_addr[t]][0]; // Reset bits above enable bits
            c[t]   = exp_reg[en_addr[t]][0];
        end
        return c;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, expected);
        end
    endtask

    // One clock that records the pc capture and then drives the next thread and pc
    task automatic tick();
        logic [31:0] w;
        @(posedge qclk);
        exp_pc[next_idx(thread_onehot)] = pc;
        #1;
        if (rotate) begin
            thread_onehot = {thread_onehot[2:0], thread_onehot[3]};
        end
        rand_word(w);
        pc = w;
    endtask

    task automatic read_check(input logic on_ring, input logic [15:0] addr,
                              input logic [31:0] expected);
        if (on_ring) begin
            ring_req = make_req(addr, '0, 1'b1, 1'b0);
        end else begin
            core_req = make_req(addr, '0, 1'b1, 1'b0);
        end
        tick();
        core_req = '0;
        ring_req = '0;
        if (on_ring) begin
            compare_word($sformatf("ring_rd_data[%h]", addr), ring_rd_data, expected);
        end else begin
            compare_word($sformatf("core_rd_data[%h]", addr), core_rd_data, expected);
        end
    endtask

    task automatic write_reg(input logic on_ring, input logic [15:0] addr,
                             input logic [31:0] data);
        if (on_ring) begin
            ring_req = make_req(addr, data, 1'b0, 1'b1);
        end else begin
            core_req = make_req(addr, data, 1'b0, 1'b1);
        end
        tick();
        core_req = '0;
        ring_req = '0;
        exp_reg[addr] = reg_value(addr, data);
        compare_word("thread_ctrl", {24'd0, thread_ctrl}, {24'd0, exp_ctrl()});
    endtask

    task automatic init_model();
        rst_addr = '{cr_pkg::CR_THREAD0_PC_RST, cr_pkg::CR_THREAD1_PC_RST,
                     cr_pkg::CR_THREAD2_PC_RST, cr_pkg::CR_THREAD3_PC_RST};
        en_addr  = '{cr_pkg::CR_THREAD0_PC_EN, cr_pkg::CR_THREAD1_PC_EN,
                     cr_pkg::CR_THREAD2_PC_EN, cr_pkg::CR_THREAD3_PC_EN};
        stk_addr = '{cr_pkg::CR_THREAD0_STACK_BASE_OFFSET, cr_pkg::CR_THREAD1_STACK_BASE_OFFSET,
                     cr_pkg::CR_THREAD2_STACK_BASE_OFFSET, cr_pkg::CR_THREAD3_STACK_BASE_OFFSET};
        tls_addr = '{cr_pkg::CR_THREAD0_TLS_BASE_OFFSET, cr_pkg::CR_THREAD1_TLS_BASE_OFFSET,
                     cr_pkg::CR_THREAD2_TLS_BASE_OFFSET, cr_pkg::CR_THREAD3_TLS_BASE_OFFSET};
        pc_addr  = '{cr_pkg::CR_THREAD0_PC, cr_pkg::CR_THREAD1_PC,
                     cr_pkg::CR_THREAD2_PC, cr_pkg::CR_THREAD3_PC};
        pad_addr = '{cr_pkg::CR_SCRATCHPAD0, cr_pkg::CR_SCRATCHPAD1,
                     cr_pkg::CR_SCRATCHPAD2, cr_pkg::CR_SCRATCHPAD3};
        for (int t = 0; t < 4; t++) begin
            exp_reg[rst_addr[t]] = 32'd0;
            exp_reg[en_addr[t]]  = 32'd1;
            exp_reg[stk_addr[t]] = 32'h0040_0200 + 32'h200 * t; // 400200 up to 400800
            exp_reg[tls_addr[t]] = 32'h0040_0200 + 32'h200 * t;
            exp_reg[pad_addr[t]] = 32'd0;
            writable.push_back(rst_addr[t]);
            writable.push_back(en_addr[t]);
            writable.push_back(stk_addr[t]);
            writable.push_back(tls_addr[t]);
            writable.push_back(pad_addr[t]);
        end
        exp_reg[cr_pkg::CR_SHARED_BASE_OFFSET] = 32'h0040_0F00;
        writable.push_back(cr_pkg::CR_SHARED_BASE_OFFSET);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_values();
        compare_word("thread_ctrl", {24'd0, thread_ctrl}, 32'h0000_000F);
        foreach (writable[i]) begin
            read_check(1'b0, writable[i], exp_reg[writable[i]]);
        end
    endtask

    task automatic test_write_readback();
        logic [31:0] data;
        logic        on_ring;
        foreach (writable[i]) begin
            rand_word(data);
            on_ring = (i % 2) == 1; // Alternate the writing port
            write_reg(on_ring, writable[i], data);
            read_check(!on_ring, writable[i], exp_reg[writable[i]]);
        end
    endtask

    task automatic test_simultaneous();
        logic [31:0] a;
        logic [31:0] b;
        rand_word(a);
        rand_word(b);
        core_req = make_req(pad_addr[2], a, 1'b0, 1'b1);
        ring_req = make_req(pad_addr[2], b, 1'b0, 1'b1);
        tick();
        exp_reg[pad_addr[2]] = b; // Ring wins
        rand_word(a);
        rand_word(b);
        core_req = make_req(pad_addr[0], a, 1'b0, 1'b1);
        ring_req = make_req(tls_addr[1], b, 1'b0, 1'b1);
        tick();
        core_req = '0;
        ring_req = '0;
        exp_reg[pad_addr[0]] = a;
        exp_reg[tls_addr[1]] = b;
        read_check(1'b0, pad_addr[2], exp_reg[pad_addr[2]]);
        read_check(1'b1, pad_addr[0], exp_reg[pad_addr[0]]);
        read_check(1'b0, tls_addr[1], exp_reg[tls_addr[1]]);
    endtask

    task automatic test_thread_sampling();
        logic [1:0] idx;
        rotate = 1'b0;
        for (int k = 0; k < 4; k++) begin
            thread_onehot = 4'b0001 << k;
            idx = k[1:0] + 2'd1;     // Sampled thread is one past the execute thread
            tick();
            tick();
            read_check(1'b0, cr_pkg::CR_THREAD_ID, {30'd0, idx});
            read_check(1'b1, cr_pkg::CR_CORE_ID, {24'd0, core_id_strap});
            read_check(1'b0, cr_pkg::CR_WHO_AM_I, {22'd0, core_id_strap, idx});
            read_check(1'b1, cr_pkg::CR_STACK_BASE_OFFSET, exp_reg[stk_addr[idx]]);
            read_check(1'b0, cr_pkg::CR_TLS_BASE_OFFSET, exp_reg[tls_addr[idx]]);
        end
    endtask

    task automatic test_pc_capture();
        rotate = 1'b0;
        for (int k = 0; k < 4; k++) begin
            thread_onehot = 4'b0001 << k;
            repeat (2 + k) tick();
        end
        for (int t = 0; t < 4; t++) begin
            read_check(t[0], pc_addr[t], exp_pc[t]);
        end
    endtask

    task automatic test_zero_returns();
        read_check(1'b1, cr_pkg::CR_SHARED_BASE_OFFSET, exp_reg[cr_pkg::CR_SHARED_BASE_OFFSET]);
        read_check(1'b1, 16'hC418, 32'd0);  // Gap in the address map
        read_check(1'b0, cr_pkg::CR_SHARED_BASE_OFFSET, exp_reg[cr_pkg::CR_SHARED_BASE_OFFSET]);
        tick();
        compare_word("core_rd_data idle", core_rd_data, 32'd0);
    endtask

    initial begin
        lfsr          = 32'he562c1a7;
        reset         = 1'b1;
        core_id_strap = 8'h5A;
        core_req      = '0;
        ring_req      = '0;
        thread_onehot = 4'b0001;
        pc            = '0;
        rotate        = 1'b1;
        errors        = 0;
        checks        = 0;
        init_model();
        repeat (10) tick();
        reset = 1'b0;
        test_reset_values();
        test_write_readback();
        test_simultaneous();
        test_thread_sampling();
        test_pc_capture();
        test_zero_returns();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/cr_mem.sv
// Control-register block of a four-thread core, with a core port and a ring port
// Both ports may read and write in the same cycle; the ring wins on a write clash
// Read data is registered and appears one cycle after rd_en
`timescale 1ns/1ps
`default_nettype none

module cr_mem (
    input  wire logic                            qclk,
    input  wire logic                            reset,
    input  wire logic [cr_pkg::CORE_ID_W-1:0]    core_id_strap,
    input  wire cr_pkg::cr_req_t                 core_req,
    input  wire cr_pkg::cr_req_t                 ring_req,
    input  wire logic [cr_pkg::NUM_THREADS-1:0]  thread_onehot, // Thread in execute
    input  wire logic [cr_pkg::CR_DATA_W-1:0]    pc,
    output cr_pkg::thread_ctrl_t                 thread_ctrl,
    output logic [cr_pkg::CR_DATA_W-1:0]         core_rd_data,
    output logic [cr_pkg::CR_DATA_W-1:0]         ring_rd_data
);

    cr_pkg::cr_wr_en_t wr_en;
    cr_pkg::cr_rw_t    wr_data; // Per-register candidate values
    cr_pkg::cr_rw_t    rw;
    cr_pkg::cr_hw_t    hw;

    cr_write_decode u_wr_dec (
        .core_req (core_req),
        .ring_req (ring_req),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    cr_rw_regs u_rw_regs (
        .qclk        (qclk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rw          (rw),
        .thread_ctrl (thread_ctrl)
    );

    cr_thread_sampler u_sampler (
        .qclk          (qclk),
        .reset         (reset),
        .thread_onehot (thread_onehot),
        .pc            (pc),
        .core_id_strap (core_id_strap),
        .rw            (rw),
        .hw            (hw)
    );

    cr_read_port u_core_rd (
        .qclk    (qclk),
        .reset   (reset),
        .req     (core_req),
        .rw      (rw),
        .hw      (hw),
        .rd_data (core_rd_data)
    );

    cr_read_port u_ring_rd (
        .qclk    (qclk),
        .reset   (reset),
        .req     (ring_req),
        .rw      (rw),
        .hw      (hw),
        .rd_data (ring_rd_data)
    );

endmodule

`default_nettype wire

// File: hw/cr_read_port.sv
// Registered read port, one per access port
// Data of the addressed register appears one cycle after rd_en, zero-extended;
// no rd_en or an unmapped address returns zero
`timescale 1ns/1ps
`default_nettype none

module cr_read_port (
    input  wire logic                     qclk,
    input  wire logic                     reset,
    input  wire cr_pkg::cr_req_t          req,
    input  wire cr_pkg::cr_rw_t           rw,
    input  wire cr_pkg::cr_hw_t           hw,
    output logic [cr_pkg::CR_DATA_W-1:0]  rd_data
);

    logic [cr_pkg::CR_DATA_W-1:0] rd_next;

    // ==============================
    // Address mux
    // ==============================
    always_comb begin
        rd_next = '0;
        if (req.rd_en) begin
            case (req.addr)
                cr_pkg::CR_WHO_AM_I : begin
                    rd_next[cr_pkg::CORE_ID_W+cr_pkg::THREAD_ID_W-1:0] =
                        {hw.core_id, hw.thread_id}; // Core id above thread id
                end
                cr_pkg::CR_THREAD_ID                 : rd_next[1:0] = hw.thread_id;
                cr_pkg::CR_CORE_ID                   : rd_next[7:0] = hw.core_id;
                cr_pkg::CR_STACK_BASE_OFFSET         : rd_next = hw.stk_ofst;
                cr_pkg::CR_TLS_BASE_OFFSET           : rd_next = hw.tls_ofst;
                cr_pkg::CR_SHARED_BASE_OFFSET        : rd_next = rw.shrd_ofst;
                cr_pkg::CR_THREAD0_PC_RST            : rd_next[0] = rw.ctrl.rst_pc[0];
                cr_pkg::CR_THREAD1_PC_RST            : rd_next[0] = rw.ctrl.rst_pc[1];
                cr_pkg::CR_THREAD2_PC_RST            : rd_next[0] = rw.ctrl.rst_pc[2];
                cr_pkg::CR_THREAD3_PC_RST            : rd_next[0] = rw.ctrl.rst_pc[3];
                cr_pkg::CR_THREAD0_PC_EN             : rd_next[0] = rw.ctrl.en_pc[0];
                cr_pkg::CR_THREAD1_PC_EN             : rd_next[0] = rw.ctrl.en_pc[1];
                cr_pkg::CR_THREAD2_PC_EN             : rd_next[0] = rw.ctrl.en_pc[2];
                cr_pkg::CR_THREAD3_PC_EN             : rd_next[0] = rw.ctrl.en_pc[3];
                cr_pkg::CR_THREAD0_STACK_BASE_OFFSET : rd_next = rw.stk_ofst[0];
                cr_pkg::CR_THREAD1_STACK_BASE_OFFSET : rd_next = rw.stk_ofst[1];
                cr_pkg::CR_THREAD2_STACK_BASE_OFFSET : rd_next = rw.stk_ofst[2];
                cr_pkg::CR_THREAD3_STACK_BASE_OFFSET : rd_next = rw.stk_ofst[3];
                cr_pkg::CR_THREAD0_TLS_BASE_OFFSET   : rd_next = rw.tls_ofst[0];
                cr_pkg::CR_THREAD1_TLS_BASE_OFFSET   : rd_next = rw.tls_ofst[1];
                cr_pkg::CR_THREAD2_TLS_BASE_OFFSET   : rd_next = rw.tls_ofst[2];
                cr_pkg::CR_THREAD3_TLS_BASE_OFFSET   : rd_next = rw.tls_ofst[3];
                cr_pkg::CR_THREAD0_PC                : rd_next = hw.pc[0];
                cr_pkg::CR_THREAD1_PC                : rd_next = hw.pc[1];
                cr_pkg::CR_THREAD2_PC                : rd_next = hw.pc[2];
                cr_pkg::CR_THREAD3_PC                : rd_next = hw.pc[3];
                cr_pkg::CR_SCRATCHPAD0               : rd_next = rw.scratch_pad[0];
                cr_pkg::CR_SCRATCHPAD1               : rd_next = rw.scratch_pad[1];
                cr_pkg::CR_SCRATCHPAD2               : rd_next = rw.scratch_pad[2];
                cr_pkg::CR_SCRATCHPAD3               : rd_next = rw.scratch_pad[3];
                default                              : rd_next = '0;
            endcase
        end
    end

    always_ff @(posedge qclk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_next; // Pre-write register state
        end
    end

    a_no_rd_wr : assert property (@(posedge qclk) disable iff (reset) !(req.rd_en && req.wr_en))
        else $error("read and write on one port at %h", req.addr);

endmodule

`default_nettype wire

// File: hw/cr_thread_sampler.sv
// Hardware-sampled registers tied to the thread rotation
// The sampled thread is the one after the execute-stage thread; a non-one-hot input
// selects thread 3. PC capture registers are not reset and hold garbage until written
`timescale 1ns/1ps
`default_nettype none

module cr_thread_sampler (
    input  wire logic                             qclk,
    input  wire logic                             reset,
    input  wire logic [cr_pkg::NUM_THREADS-1:0]   thread_onehot,
    input  wire logic [cr_pkg::CR_DATA_W-1:0]     pc,
    input  wire logic [cr_pkg::CORE_ID_W-1:0]     core_id_strap,
    input  wire cr_pkg::cr_rw_t                   rw,
    output cr_pkg::cr_hw_t                        hw
);

    logic [cr_pkg::NUM_THREADS-1:0] thread_next;
    logic [cr_pkg::THREAD_ID_W-1:0] thread_idx;

    // Rotate up by one, thread 3 wraps to thread 0
    assign thread_next = {thread_onehot[cr_pkg::NUM_THREADS-2:0],
                          thread_onehot[cr_pkg::NUM_THREADS-1]};

    always_comb begin
        case (thread_next)
            4'b0001 : thread_idx = 2'd0;
            4'b0010 : thread_idx = 2'd1;
            4'b0100 : thread_idx = 2'd2;
            default : thread_idx = 2'd3;
        endcase
    end

    always_ff @(posedge qclk) begin
        if (reset) begin
            hw.thread_id <= '0;
        end else begin
            hw.thread_id <= thread_idx;
        end
        hw.core_id         <= core_id_strap;           // Static strap
        hw.stk_ofst        <= rw.stk_ofst[thread_idx];
        hw.tls_ofst        <= rw.tls_ofst[thread_idx];
        hw.pc[thread_idx]  <= pc;                      // Each pc updates once per rotation
    end

    a_onehot : assert property (@(posedge qclk) disable iff (reset) $onehot(thread_onehot))
        else $error("thread_onehot not one-hot: %b", thread_onehot);

endmodule

`default_nettype wire

// File: hw/cr_rw_regs.sv
// Writable control registers
// Each register loads its candidate value on the clock edge that ends its enable cycle
// Thread PC reset bits come up clear and PC enable bits set, so all threads run
`timescale 1ns/1ps
`default_nettype none

module cr_rw_regs (
    input  wire logic              qclk,
    input  wire logic              reset,
    input  wire cr_pkg::cr_wr_en_t wr_en,
    input  wire cr_pkg::cr_rw_t    wr_data,
    output cr_pkg::cr_rw_t         rw,
    output cr_pkg::thread_ctrl_t   thread_ctrl
);

    always_ff @(posedge qclk) begin
        if (reset) begin
            rw.ctrl        <= cr_pkg::THREAD_CTRL_RST;
            rw.stk_ofst    <= cr_pkg::STK_OFST_RST;
            rw.tls_ofst    <= cr_pkg::TLS_OFST_RST;
            rw.shrd_ofst   <= cr_pkg::SHRD_OFST_RST;
            rw.scratch_pad <= '0;
        end else begin
            for (int t = 0; t < cr_pkg::NUM_THREADS; t++) begin
                if (wr_en.rst_pc[t]) begin
                    rw.ctrl.rst_pc[t] <= wr_data.ctrl.rst_pc[t];
                end
                if (wr_en.en_pc[t]) begin
                    rw.ctrl.en_pc[t] <= wr_data.ctrl.en_pc[t];
                end
                if (wr_en.stk_ofst[t]) begin
                    rw.stk_ofst[t] <= wr_data.stk_ofst[t];
                end
                if (wr_en.tls_ofst[t]) begin
                    rw.tls_ofst[t] <= wr_data.tls_ofst[t];
                end
                if (wr_en.scratch_pad[t]) begin
                    rw.scratch_pad[t] <= wr_data.scratch_pad[t];
                end
            end
            if (wr_en.shrd_ofst) begin
                rw.shrd_ofst <= wr_data.shrd_ofst;
            end
        end
    end

    assign thread_ctrl = rw.ctrl; // Straight to the core

endmodule

`default_nettype wire

// File: hw/cr_write_decode.sv
// Write decode for the core and ring ports
// A clash on one register resolves to the ring data; writes to read-only
// or unmapped addresses produce no enable
`timescale 1ns/1ps
`default_nettype none

module cr_write_decode (
    input  wire cr_pkg::cr_req_t core_req,
    input  wire cr_pkg::cr_req_t ring_req,
    output cr_pkg::cr_wr_en_t    wr_en,
    output cr_pkg::cr_rw_t       wr_data
);

    cr_pkg::cr_wr_en_t core_en;
    cr_pkg::cr_wr_en_t ring_en;

    function automatic cr_pkg::cr_wr_en_t decode(input cr_pkg::cr_req_t req);
        cr_pkg::cr_wr_en_t en;
        en = '0;
        if (req.wr_en) begin
            case (req.addr)
                cr_pkg::CR_THREAD0_PC_RST            : en.rst_pc[0]      = 1'b1;
                cr_pkg::CR_THREAD1_PC_RST            : en.rst_pc[1]      = 1'b1;
                cr_pkg::CR_THREAD2_PC_RST            : en.rst_pc[2]      = 1'b1;
                cr_pkg::CR_THREAD3_PC_RST            : en.rst_pc[3]      = 1'b1;
                cr_pkg::CR_THREAD0_PC_EN             : en.en_pc[0]       = 1'b1;
                cr_pkg::CR_THREAD1_PC_EN             : en.en_pc[1]       = 1'b1;
                cr_pkg::CR_THREAD2_PC_EN             : en.en_pc[2]       = 1'b1;
                cr_pkg::CR_THREAD3_PC_EN             : en.en_pc[3]       = 1'b1;
                cr_pkg::CR_THREAD0_STACK_BASE_OFFSET : en.stk_ofst[0]    = 1'b1;
                cr_pkg::CR_THREAD1_STACK_BASE_OFFSET : en.stk_ofst[1]    = 1'b1;
                cr_pkg::CR_THREAD2_STACK_BASE_OFFSET : en.stk_ofst[2]    = 1'b1;
                cr_pkg::CR_THREAD3_STACK_BASE_OFFSET : en.stk_ofst[3]    = 1'b1;
                cr_pkg::CR_THREAD0_TLS_BASE_OFFSET   : en.tls_ofst[0]    = 1'b1;
                cr_pkg::CR_THREAD1_TLS_BASE_OFFSET   : en.tls_ofst[1]    = 1'b1;
                cr_pkg::CR_THREAD2_TLS_BASE_OFFSET   : en.tls_ofst[2]    = 1'b1;
                cr_pkg::CR_THREAD3_TLS_BASE_OFFSET   : en.tls_ofst[3]    = 1'b1;
                cr_pkg::CR_SHARED_BASE_OFFSET        : en.shrd_ofst      = 1'b1;
                cr_pkg::CR_SCRATCHPAD0               : en.scratch_pad[0] = 1'b1;
                cr_pkg::CR_SCRATCHPAD1               : en.scratch_pad[1] = 1'b1;
                cr_pkg::CR_SCRATCHPAD2               : en.scratch_pad[2] = 1'b1;
                cr_pkg::CR_SCRATCHPAD3               : en.scratch_pad[3] = 1'b1;
                default                              : ; // Read-only or unmapped
            endcase
        end
        return en;
    endfunction

    // Hardware-sampled registers that are mapped but not writable
    function automatic logic is_ro(input logic [cr_pkg::CR_ADDR_W-1:0] addr);
        return addr inside {cr_pkg::CR_WHO_AM_I, cr_pkg::CR_THREAD_ID, cr_pkg::CR_CORE_ID,
                            cr_pkg::CR_STACK_BASE_OFFSET, cr_pkg::CR_TLS_BASE_OFFSET,
                            cr_pkg::CR_THREAD0_PC, cr_pkg::CR_THREAD1_PC,
                            cr_pkg::CR_THREAD2_PC, cr_pkg::CR_THREAD3_PC};
    endfunction

    assign core_en = decode(core_req);
    assign ring_en = decode(ring_req);
    assign wr_en   = core_en | ring_en;

    // Ring data wherever the ring enabled that register
    always_comb begin
        for (int t = 0; t < cr_pkg::NUM_THREADS; t++) begin
            wr_data.ctrl.rst_pc[t] = ring_en.rst_pc[t] ? ring_req.wr_data[0] : core_req.wr_data[0];
            wr_data.ctrl.en_pc[t]  = ring_en.en_pc[t]  ? ring_req.wr_data[0] : core_req.wr_data[0];
            wr_data.stk_ofst[t]    = ring_en.stk_ofst[t] ? ring_req.wr_data : core_req.wr_data;
            wr_data.tls_ofst[t]    = ring_en.tls_ofst[t] ? ring_req.wr_data : core_req.wr_data;
            wr_data.scratch_pad[t] = ring_en.scratch_pad[t] ? ring_req.wr_data : core_req.wr_data;
        end
        wr_data.shrd_ofst = ring_en.shrd_ofst ? ring_req.wr_data : core_req.wr_data;
    end

    // A write strobe must hit some mapped register even if read-only
    always_comb begin
        if (core_req.wr_en) begin
            assert ((|decode(core_req)) || is_ro(core_req.addr))
                else $error("core write to unmapped address %h", core_req.addr);
        end
        if (ring_req.wr_en) begin
            assert ((|decode(ring_req)) || is_ro(ring_req.addr))
                else $error("ring write to unmapped address %h", ring_req.addr);
        end
    end

endmodule

`default_nettype wire

// File: hw/cr_pkg.sv
// Shared widths, address map, reset values and types of the control-register block
// Every register is one 32-bit word; an address not listed here is unmapped
// Reset values of the offset registers match the default memory layout of the core
`default_nettype none

package cr_pkg;

    // ==============================
    // Widths and counts
    // ==============================
    localparam int CR_DATA_W   = 32;
    localparam int CR_ADDR_W   = 16;
    localparam int NUM_THREADS = 4;
    localparam int THREAD_ID_W = 2;
    localparam int CORE_ID_W   = 8;

    // ==============================
    // Address map
    // ==============================
    localparam logic [CR_ADDR_W-1:0] CR_WHO_AM_I                  = 16'hC400;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD_ID                 = 16'hC404;
    localparam logic [CR_ADDR_W-1:0] CR_CORE_ID                   = 16'hC408;
    localparam logic [CR_ADDR_W-1:0] CR_STACK_BASE_OFFSET         = 16'hC40C; // Current thread
    localparam logic [CR_ADDR_W-1:0] CR_TLS_BASE_OFFSET           = 16'hC410; // Current thread
    localparam logic [CR_ADDR_W-1:0] CR_SHARED_BASE_OFFSET        = 16'hC414;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD0_PC_RST            = 16'hC420;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD1_PC_RST            = 16'hC424;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD2_PC_RST            = 16'hC428;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD3_PC_RST            = 16'hC42C;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD0_PC_EN             = 16'hC430;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD1_PC_EN             = 16'hC434;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD2_PC_EN             = 16'hC438;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD3_PC_EN             = 16'hC43C;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD0_STACK_BASE_OFFSET = 16'hC440;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD1_STACK_BASE_OFFSET = 16'hC444;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD2_STACK_BASE_OFFSET = 16'hC448;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD3_STACK_BASE_OFFSET = 16'hC44C;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD0_TLS_BASE_OFFSET   = 16'hC450;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD1_TLS_BASE_OFFSET   = 16'hC454;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD2_TLS_BASE_OFFSET   = 16'hC458;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD3_TLS_BASE_OFFSET   = 16'hC45C;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD0_PC                = 16'hC460; // Read only
    localparam logic [CR_ADDR_W-1:0] CR_THREAD1_PC                = 16'hC464;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD2_PC                = 16'hC468;
    localparam logic [CR_ADDR_W-1:0] CR_THREAD3_PC                = 16'hC46C;
    localparam logic [CR_ADDR_W-1:0] CR_SCRATCHPAD0               = 16'hC470;
    localparam logic [CR_ADDR_W-1:0] CR_SCRATCHPAD1               = 16'hC474;
    localparam logic [CR_ADDR_W-1:0] CR_SCRATCHPAD2               = 16'hC478;
    localparam logic [CR_ADDR_W-1:0] CR_SCRATCHPAD3               = 16'hC47C;

    // ==============================
    // Types
    // ==============================
    typedef struct packed {
        logic [CR_ADDR_W-1:0] addr;
        logic [CR_DATA_W-1:0] wr_data;
        logic                 rd_en;
        logic                 wr_en;
    } cr_req_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0] rst_pc; // Hold thread PC in reset
        logic [NUM_THREADS-1:0] en_pc;  // Let thread PC advance
    } thread_ctrl_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0] rst_pc;
        logic [NUM_THREADS-1:0] en_pc;
        logic [NUM_THREADS-1:0] stk_ofst;
        logic [NUM_THREADS-1:0] tls_ofst;
        logic                   shrd_ofst;
        logic [NUM_THREADS-1:0] scratch_pad;
    } cr_wr_en_t;

    typedef struct packed {
        thread_ctrl_t                          ctrl;
        logic [NUM_THREADS-1:0][CR_DATA_W-1:0] stk_ofst;
        logic [NUM_THREADS-1:0][CR_DATA_W-1:0] tls_ofst;
        logic [CR_DATA_W-1:0]                  shrd_ofst;
        logic [NUM_THREADS-1:0][CR_DATA_W-1:0] scratch_pad;
    } cr_rw_t;

    typedef struct packed {
        logic [THREAD_ID_W-1:0]                thread_id;
        logic [CORE_ID_W-1:0]                  core_id;
        logic [CR_DATA_W-1:0]                  stk_ofst;
        logic [CR_DATA_W-1:0]                  tls_ofst;
        logic [NUM_THREADS-1:0][CR_DATA_W-1:0] pc;
    } cr_hw_t;

    // ==============================
    // Reset values
    // ==============================
    localparam logic [NUM_THREADS-1:0][CR_DATA_W-1:0] STK_OFST_RST =
        {32'h0040_0800, 32'h0040_0600, 32'h0040_0400, 32'h0040_0200};
    localparam logic [NUM_THREADS-1:0][CR_DATA_W-1:0] TLS_OFST_RST =
        {32'h0040_0800, 32'h0040_0600, 32'h0040_0400, 32'h0040_0200};
    localparam logic [CR_DATA_W-1:0] SHRD_OFST_RST = 32'h0040_0F00;
    localparam thread_ctrl_t THREAD_CTRL_RST = '{rst_pc: '0, en_pc: '1}; // All threads run

endpackage

`default_nettype wire
